//--- hw/cfg_regs.sv
// Configuration register device: freeze, device ids and a scratch word
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  import tile_pkg::*;
#(
  parameter int DID_W = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,

  input  logic             cmd_v_i,
  output logic             cmd_ready_o,
  input  mem_msg_s         cmd_i,

  output logic             resp_v_o,
  input  logic             resp_ready_i,
  output mem_msg_s         resp_o,

  input  logic [DID_W-1:0] my_did_i,
  input  logic [DID_W-1:0] host_did_i,
  output logic             freeze_o
);

  logic              resp_v_r;
  mem_msg_s          resp_r;
  logic              freeze_r;
  logic [DATA_W-1:0] scratch_r;
  logic [DATA_W-1:0] rd_data;
  paddr_u            cmd_addr;
  logic              cmd_fire;
  logic              wr_en;

  assign cmd_addr    = cmd_i.addr;
  assign cmd_ready_o = !resp_v_r;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;
  assign wr_en       = cmd_fire && (cmd_i.op == MEM_WR);

  always_comb begin
    case (cmd_addr.loc.ofs)
      CFG_FREEZE_OFS:   rd_data = DATA_W'(freeze_r);
      CFG_DID_OFS:      rd_data = DATA_W'(my_did_i);
      CFG_HOST_DID_OFS: rd_data = DATA_W'(host_did_i);
      CFG_SCRATCH_OFS:  rd_data = scratch_r;
      default:          rd_data = '0;
    endcase
  end

  // Core held frozen until software clears it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      freeze_r  <= 1'b1;
      scratch_r <= '0;
    end else if (wr_en) begin
      if (cmd_addr.loc.ofs == CFG_FREEZE_OFS) begin
        freeze_r <= cmd_i.data[0];
      end
      if (cmd_addr.loc.ofs == CFG_SCRATCH_OFS) begin
        scratch_r <= cmd_i.data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_r <= 1'b0;
    end else if (cmd_fire) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= (cmd_i.op == MEM_RD) ? rd_data : '0;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o   = resp_r;
  assign freeze_o = freeze_r;

  a_cmd_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_v_i && !cmd_ready_o) |=> (cmd_v_i && $stable(cmd_i)));

endmodule

`default_nettype wire

//--- hw/clint_timer.sv
// Core-local interruptor: prescaled machine timer, compare register and software interrupt
`timescale 1ns/1ps
`default_nettype none

module clint_timer
  import tile_pkg::*;
#(
  parameter int TICK_DIV = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  input  mem_msg_s cmd_i,

  output logic     resp_v_o,
  input  logic     resp_ready_i,
  output mem_msg_s resp_o,

  output logic     timer_irq_o,
  output logic     software_irq_o
);

  localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [PRE_W-1:0]  pre_cnt_r;
  logic              tick;
  logic [DATA_W-1:0] mtime_r;
  logic [DATA_W-1:0] mtimecmp_r;
  logic              msip_r;
  logic              resp_v_r;
  mem_msg_s          resp_r;
  logic [DATA_W-1:0] rd_data;
  paddr_u            cmd_addr;
  logic              cmd_fire;
  logic              wr_en;

  assign cmd_addr    = cmd_i.addr;
  assign cmd_ready_o = !resp_v_r;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;
  assign wr_en       = cmd_fire && (cmd_i.op == MEM_WR);

  // Prescaler, one mtime step every TICK_DIV cycles
  assign tick = (pre_cnt_r == PRE_W'(TICK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i || tick) begin
      pre_cnt_r <= '0;
    end else begin
      pre_cnt_r <= pre_cnt_r + 1'b1;
    end
  end

  // Software write wins over the tick
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_r <= '0;
    end else if (wr_en && (cmd_addr.loc.ofs == CLINT_MTIME_OFS)) begin
      mtime_r <= cmd_i.data;
    end else if (tick) begin
      mtime_r <= mtime_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end else if (wr_en) begin
      if (cmd_addr.loc.ofs == CLINT_MTIMECMP_OFS) begin
        mtimecmp_r <= cmd_i.data;
      end
      if (cmd_addr.loc.ofs == CLINT_MSIP_OFS) begin
        msip_r <= cmd_i.data[0];
      end
    end
  end

  always_comb begin
    case (cmd_addr.loc.ofs)
      CLINT_MSIP_OFS:     rd_data = DATA_W'(msip_r);
      CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      CLINT_MTIME_OFS:    rd_data = mtime_r;
      default:            rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_r <= 1'b0;
    end else if (cmd_fire) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_r.op   <= cmd_i.op;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= (cmd_i.op == MEM_RD) ? rd_data : '0;
    end
  end

  assign resp_v_o       = resp_v_r;
  assign resp_o         = resp_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

  a_cmd_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_v_i && !cmd_ready_o) |=> (cmd_v_i && $stable(cmd_i)));

endmodule

`default_nettype wire

//--- hw/dev_cmd_router.sv
// Command router: decodes the address, steers one command at a time and returns the response
`timescale 1ns/1ps
`default_nettype none

module dev_cmd_router
  import tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  input  mem_msg_s cmd_i,

  output logic     resp_v_o,
  input  logic     resp_ready_i,
  output mem_msg_s resp_o,

  output mem_msg_s dev_cmd_o,
  output logic     mem_cmd_v_o,
  output logic     cfg_cmd_v_o,
  output logic     clint_cmd_v_o,
  input  logic     mem_cmd_ready_i,
  input  logic     cfg_cmd_ready_i,
  input  logic     clint_cmd_ready_i,

  input  logic     mem_resp_v_i,
  input  logic     cfg_resp_v_i,
  input  logic     clint_resp_v_i,
  input  mem_msg_s mem_resp_i,
  input  mem_msg_s cfg_resp_i,
  input  mem_msg_s clint_resp_i,
  output logic     mem_resp_ready_o,
  output logic     cfg_resp_ready_o,
  output logic     clint_resp_ready_o
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_SEND = 2'd1,
    ST_WAIT = 2'd2
  } state_e;

  state_e   state_r;
  state_e   state_n;
  mem_msg_s cmd_r;
  dst_e     dst_r;
  dst_e     dst_dec;
  paddr_u   dec_addr;
  logic     is_local;
  logic     cmd_fire;
  logic     dev_ready;
  logic     sel_resp_v;
  mem_msg_s sel_resp;
  mem_msg_s loop_resp;
  logic     resp_fire;

  assign dec_addr = cmd_i.addr;
  assign is_local = (dec_addr.raw < DRAM_BASE);

  // Cache hits are served by the memory port
  always_comb begin
    if (!is_local) begin
      dst_dec = DST_MEM;
    end else if (dec_addr.loc.dev == CFG_DEV) begin
      dst_dec = DST_CFG;
    end else if (dec_addr.loc.dev == CLINT_DEV) begin
      dst_dec = DST_CLINT;
    end else if (dec_addr.loc.dev == CACHE_DEV) begin
      dst_dec = DST_MEM;
    end else begin
      dst_dec = DST_LOOP;
    end
  end

  assign cmd_ready_o = (state_r == ST_IDLE);
  assign cmd_fire    = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      cmd_r <= cmd_i;
      dst_r <= dst_dec;
    end
  end

  // Command steering
  assign dev_cmd_o     = cmd_r;
  assign mem_cmd_v_o   = (state_r == ST_SEND) && (dst_r == DST_MEM);
  assign cfg_cmd_v_o   = (state_r == ST_SEND) && (dst_r == DST_CFG);
  assign clint_cmd_v_o = (state_r == ST_SEND) && (dst_r == DST_CLINT);

  // Loopback echo of the held command
  assign loop_resp = '{op: cmd_r.op, addr: cmd_r.addr, data: '0};

  always_comb begin
    case (dst_r)
      DST_MEM: begin
        dev_ready  = mem_cmd_ready_i;
        sel_resp_v = mem_resp_v_i;
        sel_resp   = mem_resp_i;
      end
      DST_CFG: begin
        dev_ready  = cfg_cmd_ready_i;
        sel_resp_v = cfg_resp_v_i;
        sel_resp   = cfg_resp_i;
      end
      DST_CLINT: begin
        dev_ready  = clint_cmd_ready_i;
        sel_resp_v = clint_resp_v_i;
        sel_resp   = clint_resp_i;
      end
      default: begin
        dev_ready  = 1'b1;
        sel_resp_v = 1'b1;
        sel_resp   = loop_resp;
      end
    endcase
  end

  assign resp_v_o  = (state_r == ST_WAIT) && sel_resp_v;
  assign resp_o    = sel_resp;
  assign resp_fire = resp_v_o && resp_ready_i;

  assign mem_resp_ready_o   = (state_r == ST_WAIT) && (dst_r == DST_MEM) && resp_ready_i;
  assign cfg_resp_ready_o   = (state_r == ST_WAIT) && (dst_r == DST_CFG) && resp_ready_i;
  assign clint_resp_ready_o = (state_r == ST_WAIT) && (dst_r == DST_CLINT) && resp_ready_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE: begin
        if (cmd_fire) begin
          // Loopback has no device to send to
          state_n = (dst_dec == DST_LOOP) ? ST_WAIT : ST_SEND;
        end
      end
      ST_SEND: begin
        if (dev_ready) begin
          state_n = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (resp_fire) begin
          state_n = ST_IDLE;
        end
      end
      default: state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  a_resp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o)));

  a_resp_from_dst: assert property (@(posedge clk_i) disable iff (rst_i)
    (!mem_resp_v_i || dst_r == DST_MEM) && (!cfg_resp_v_i || dst_r == DST_CFG) &&
    (!clint_resp_v_i || dst_r == DST_CLINT));

endmodule

`default_nettype wire

//--- hw/dev_tile.sv
// Tile device side: command router with memory port, config registers and interruptor
`timescale 1ns/1ps
`default_nettype none

module dev_tile
  import tile_pkg::*;
#(
  parameter int DID_W    = 8,
  parameter int TICK_DIV = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,

  input  logic             cmd_v_i,
  output logic             cmd_ready_o,
  input  mem_msg_s         cmd_i,

  output logic             resp_v_o,
  input  logic             resp_ready_i,
  output mem_msg_s         resp_o,

  output logic             mem_cmd_v_o,
  input  logic             mem_cmd_ready_i,
  output mem_msg_s         mem_cmd_o,
  input  logic             mem_resp_v_i,
  output logic             mem_resp_ready_o,
  input  mem_msg_s         mem_resp_i,

  input  logic [DID_W-1:0] my_did_i,
  input  logic [DID_W-1:0] host_did_i,
  output logic             freeze_o,
  output logic             timer_irq_o,
  output logic             software_irq_o
);

  logic     cfg_cmd_v;
  logic     cfg_cmd_ready;
  logic     cfg_resp_v;
  logic     cfg_resp_ready;
  mem_msg_s cfg_resp;
  logic     clint_cmd_v;
  logic     clint_cmd_ready;
  logic     clint_resp_v;
  logic     clint_resp_ready;
  mem_msg_s clint_resp;

  // The memory port payload is also the shared device command
  dev_cmd_router i_router (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .cmd_v_i            (cmd_v_i),
    .cmd_ready_o        (cmd_ready_o),
    .cmd_i              (cmd_i),
    .resp_v_o           (resp_v_o),
    .resp_ready_i       (resp_ready_i),
    .resp_o             (resp_o),
    .dev_cmd_o          (mem_cmd_o),
    .mem_cmd_v_o        (mem_cmd_v_o),
    .cfg_cmd_v_o        (cfg_cmd_v),
    .clint_cmd_v_o      (clint_cmd_v),
    .mem_cmd_ready_i    (mem_cmd_ready_i),
    .cfg_cmd_ready_i    (cfg_cmd_ready),
    .clint_cmd_ready_i  (clint_cmd_ready),
    .mem_resp_v_i       (mem_resp_v_i),
    .cfg_resp_v_i       (cfg_resp_v),
    .clint_resp_v_i     (clint_resp_v),
    .mem_resp_i         (mem_resp_i),
    .cfg_resp_i         (cfg_resp),
    .clint_resp_i       (clint_resp),
    .mem_resp_ready_o   (mem_resp_ready_o),
    .cfg_resp_ready_o   (cfg_resp_ready),
    .clint_resp_ready_o (clint_resp_ready)
  );

  cfg_regs #(
    .DID_W (DID_W)
  ) i_cfg_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cmd_v_i      (cfg_cmd_v),
    .cmd_ready_o  (cfg_cmd_ready),
    .cmd_i        (mem_cmd_o),
    .resp_v_o     (cfg_resp_v),
    .resp_ready_i (cfg_resp_ready),
    .resp_o       (cfg_resp),
    .my_did_i     (my_did_i),
    .host_did_i   (host_did_i),
    .freeze_o     (freeze_o)
  );

  clint_timer #(
    .TICK_DIV (TICK_DIV)
  ) i_clint_timer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_v_i        (clint_cmd_v),
    .cmd_ready_o    (clint_cmd_ready),
    .cmd_i          (mem_cmd_o),
    .resp_v_o       (clint_resp_v),
    .resp_ready_i   (clint_resp_ready),
    .resp_o         (clint_resp),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

endmodule

`default_nettype wire

//--- hw/tile_pkg.sv
// Tile memory network package: address map, device ids and message formats
`default_nettype none

package tile_pkg;

  localparam int PADDR_W = 32;
  localparam int DATA_W  = 64;
  localparam int DEV_W   = 4;
  localparam int OFS_W   = 20;

  // Everything at or above this is main memory
  localparam logic [PADDR_W-1:0] DRAM_BASE = 32'h8000_0000;

  // Local device ids
  localparam logic [DEV_W-1:0] CLINT_DEV = 4'd1;
  localparam logic [DEV_W-1:0] CFG_DEV   = 4'd2;
  localparam logic [DEV_W-1:0] CACHE_DEV = 4'd5;

  // Config register offsets
  localparam logic [OFS_W-1:0] CFG_FREEZE_OFS   = 20'h0_0000;
  localparam logic [OFS_W-1:0] CFG_DID_OFS      = 20'h0_0008;
  localparam logic [OFS_W-1:0] CFG_HOST_DID_OFS = 20'h0_0010;
  localparam logic [OFS_W-1:0] CFG_SCRATCH_OFS  = 20'h0_0018;

  // Interruptor register offsets
  localparam logic [OFS_W-1:0] CLINT_MSIP_OFS     = 20'h0_0000;
  localparam logic [OFS_W-1:0] CLINT_MTIMECMP_OFS = 20'h0_4000;
  localparam logic [OFS_W-1:0] CLINT_MTIME_OFS    = 20'h0_bff8;

  typedef struct packed {
    logic [7:0]       upper;
    logic [DEV_W-1:0] dev;
    logic [OFS_W-1:0] ofs;
  } local_addr_s;

  // Same address word seen raw or split into device and offset
  typedef union packed {
    logic [PADDR_W-1:0] raw;
    local_addr_s        loc;
  } paddr_u;

  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e           op;
    paddr_u            addr;
    logic [DATA_W-1:0] data;
  } mem_msg_s;

  typedef enum logic [1:0] {
    DST_MEM   = 2'd0,
    DST_CFG   = 2'd1,
    DST_CLINT = 2'd2,
    DST_LOOP  = 2'd3
  } dst_e;

endpackage

`default_nettype wire

//--- project.f
hw/tile_pkg.sv
hw/dev_cmd_router.sv
hw/cfg_regs.sv
hw/clint_timer.sv
hw/dev_tile.sv
test/tb_dev_tile.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -j 0 \
  --top-module tb_dev_tile -Mdir "$BUILD_DIR" -f project.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_dev_tile" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  exit 0
else
  exit 1
fi

//--- test/tb_dev_tile.sv
// Testbench for the tile device side with a memory port model and protocol checks
`timescale 1ns/1ps
`default_nettype none

module tb_dev_tile
  import tile_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam logic [DATA_W-1:0] MEM_XOR = 64'h5a5a_c3c3_0f0f_9696;

  logic              clk = 1'b0;
  logic              rst;
  logic              cmd_v;
  logic              cmd_ready;
  mem_msg_s          cmd;
  logic              resp_v;
  logic              resp_ready = 1'b1;
  mem_msg_s          resp;
  logic              mem_cmd_v;
  logic              mem_cmd_ready = 1'b0;
  mem_msg_s          mem_cmd;
  logic              mem_resp_v = 1'b0;
  logic              mem_resp_ready;
  mem_msg_s          mem_resp = '0;
  logic [7:0]        my_did;
  logic [7:0]        host_did;
  logic              freeze;
  logic              timer_irq;
  logic              software_irq;

  int                seed = 32'h051e_0d10;
  int                errors = 0;
  int                n_cmd = 0;
  int                n_resp = 0;
  logic              in_flight = 1'b0;
  logic              bp_en = 1'b0;
  logic              mem_route = 1'b0;
  logic              at_least = 1'b0;
  logic              exp_freeze = 1'b1;
  logic              exp_msip = 1'b0;
  logic              cmp_set = 1'b0;
  mem_msg_s          exp_cmd = '0;
  mem_msg_s          exp_resp = '0;
  logic [DATA_W-1:0] scratch = '0;
  logic [DATA_W-1:0] last_mtime = '0;
  logic [1:0]        mem_wait = '0;
  logic              mem_busy = 1'b0;
  logic              resp_fire;

  dev_tile #(
    .DID_W    (8),
    .TICK_DIV (4)
  ) i_dev_tile (
    .clk_i            (clk),
    .rst_i            (rst),
    .cmd_v_i          (cmd_v),
    .cmd_ready_o      (cmd_ready),
    .cmd_i            (cmd),
    .resp_v_o         (resp_v),
    .resp_ready_i     (resp_ready),
    .resp_o           (resp),
    .mem_cmd_v_o      (mem_cmd_v),
    .mem_cmd_ready_i  (mem_cmd_ready),
    .mem_cmd_o        (mem_cmd),
    .mem_resp_v_i     (mem_resp_v),
    .mem_resp_ready_o (mem_resp_ready),
    .mem_resp_i       (mem_resp),
    .my_did_i         (my_did),
    .host_did_i       (host_did),
    .freeze_o         (freeze),
    .timer_irq_o      (timer_irq),
    .software_irq_o   (software_irq)
  );

  always #2 clk = ~clk;

  function automatic logic [DATA_W-1:0] mem_data(input logic [PADDR_W-1:0] addr);
    return {32'h0, addr} ^ MEM_XOR;
  endfunction

  function automatic logic [PADDR_W-1:0] local_addr(input logic [DEV_W-1:0] dev,
                                                    input logic [OFS_W-1:0] ofs);
    return {8'h00, dev, ofs};
  endfunction

  // Memory port rule: high addresses and the cache device
  function automatic logic goes_to_mem(input logic [PADDR_W-1:0] addr);
    return (addr >= DRAM_BASE) || (addr[23:20] == CACHE_DEV);
  endfunction

  task automatic report_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
    errors++;
    $display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR %0t %s", $time, what);
  endtask

  task automatic abort_run(input string why);
    $display("ERROR %0t timeout, %s", $time, why);
    $display("Commands %0d, responses %0d, errors %0d", n_cmd, n_resp, errors + 1);
    $display("Something failed");
    $finish;
  endtask

  // Memory port model, answers after 0 to 3 idle cycles
  always @(posedge clk) begin
    if (rst) begin
      mem_cmd_ready <= 1'b1;
      mem_resp_v    <= 1'b0;
      mem_busy      <= 1'b0;
    end else if (mem_resp_v) begin
      if (mem_resp_ready) begin
        mem_resp_v    <= 1'b0;
        mem_cmd_ready <= 1'b1;
      end
    end else if (mem_busy) begin
      if (mem_wait == 2'd0) begin
        mem_resp_v <= 1'b1;
        mem_busy   <= 1'b0;
      end else begin
        mem_wait <= mem_wait - 2'd1;
      end
    end else if (mem_cmd_v && mem_cmd_ready) begin
      mem_cmd_ready <= 1'b0;
      mem_busy      <= 1'b1;
      mem_wait      <= 2'($random(seed));
      mem_resp.op   <= mem_cmd.op;
      mem_resp.addr <= mem_cmd.addr;
      mem_resp.data <= (mem_cmd.op == MEM_RD) ? mem_data(mem_cmd.addr.raw) : '0;
    end
  end

  always @(posedge clk) begin
    resp_ready <= bp_en ? (($random(seed) & 1) != 0) : 1'b1;
  end

  assign resp_fire = resp_v && resp_ready;

  always @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
    end else if (cmd_v && cmd_ready) begin
      in_flight <= 1'b1;
      n_cmd     <= n_cmd + 1;
    end else if (resp_fire) begin
      in_flight <= 1'b0;
      n_resp    <= n_resp + 1;
    end
  end

  a_resp_hdr: assert property (@(posedge clk) disable iff (rst)
    resp_fire |-> (resp.op == exp_resp.op) && (resp.addr.raw == exp_resp.addr.raw))
    else report_value("resp_o", 128'($sampled(resp)), 128'($sampled(exp_resp)));
  a_resp_data: assert property (@(posedge clk) disable iff (rst)
    resp_fire |-> (at_least ? (resp.data >= exp_resp.data) : (resp.data == exp_resp.data)))
    else report_value("resp_o.data", 128'($sampled(resp.data)), 128'($sampled(exp_resp.data)));
  a_resp_stable: assert property (@(posedge clk) disable iff (rst)
    (resp_v && !resp_ready) |=> (resp_v && $stable(resp)))
    else report_error("response dropped or changed while held by back-pressure");
  a_resp_owed: assert property (@(posedge clk) disable iff (rst) resp_v |-> in_flight)
    else report_error("response without an accepted command");
  a_cmd_blocked: assert property (@(posedge clk) disable iff (rst) in_flight |-> !cmd_ready)
    else report_error("command ready while a transaction is in flight");
  a_mem_route: assert property (@(posedge clk) disable iff (rst) mem_cmd_v |-> mem_route)
    else report_error("memory port command for an address that is not memory");
  a_mem_cmd: assert property (@(posedge clk) disable iff (rst) mem_cmd_v |-> mem_cmd == exp_cmd)
    else report_value("mem_cmd_o", 128'($sampled(mem_cmd)), 128'($sampled(exp_cmd)));
  a_mem_resp_ready: assert property (@(posedge clk) disable iff (rst)
    mem_resp_v |-> (mem_resp_ready == resp_ready))
    else report_value("mem_resp_ready_o", 128'($sampled(mem_resp_ready)),
                      128'($sampled(resp_ready)));
  a_freeze: assert property (@(posedge clk) disable iff (rst)
    !in_flight |-> (freeze == exp_freeze))
    else report_value("freeze_o", 128'($sampled(freeze)), 128'($sampled(exp_freeze)));
  a_msip: assert property (@(posedge clk) disable iff (rst)
    !in_flight |-> (software_irq == exp_msip))
    else report_value("software_irq_o", 128'($sampled(software_irq)), 128'($sampled(exp_msip)));
  a_timer_early: assert property (@(posedge clk) disable iff (rst) !cmp_set |-> !timer_irq)
    else report_error("timer interrupt before the compare register was set");
  a_timer_hold: assert property (@(posedge clk) disable iff (rst) timer_irq |=> timer_irq)
    else report_error("timer interrupt dropped");

  task automatic run_cmd(input mem_op_e op, input logic [PADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rd_exp,
                         output logic [DATA_W-1:0] rdata);
    mem_msg_s msg;
    int       t;
    msg.op        = op;
    msg.addr.raw  = addr;
    msg.data      = wdata;
    exp_cmd       = msg;
    exp_resp      = msg;
    exp_resp.data = (op == MEM_RD) ? rd_exp : '0;
    mem_route     = goes_to_mem(addr);
    cmd_v <= 1'b1;
    cmd   <= msg;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!cmd_ready && t < TIMEOUT);
    if (!cmd_ready) abort_run("command not accepted");
    cmd_v <= 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!resp_fire && t < TIMEOUT);
    if (!resp_fire) abort_run("no response to command");
    rdata = resp.data;
  endtask

  // Kinds: 0 high memory, 1 cache device, 2 loopback, 3 scratch, 4 msip read
  task automatic random_txn(input int kind);
    logic [DATA_W-1:0]  rd;
    logic [DATA_W-1:0]  wd;
    logic [DATA_W-1:0]  exp;
    logic [PADDR_W-1:0] addr;
    mem_op_e            op;
    wd = {$random(seed), $random(seed)};
    op = (($random(seed) & 1) != 0) ? MEM_WR : MEM_RD;
    case (kind)
      0: addr = {1'b1, 31'($random(seed))};
      1: addr = {1'b0, 7'($random(seed)), CACHE_DEV, 20'($random(seed))};
      2: addr = {1'b0, 7'($random(seed)), 4'd7, 20'($random(seed))};
      3: addr = local_addr(CFG_DEV, CFG_SCRATCH_OFS);
      default: begin
        addr = local_addr(CLINT_DEV, CLINT_MSIP_OFS);
        op   = MEM_RD;
      end
    endcase
    case (kind)
      0, 1: exp = mem_data(addr);
      2: exp = '0;
      3: exp = scratch;
      default: exp = 64'(exp_msip);
    endcase
    run_cmd(op, addr, wd, exp, rd);
    if (kind == 3 && op == MEM_WR) scratch = wd;
  endtask

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] wd;
    int                t;
    rst      <= 1'b1;
    cmd_v    <= 1'b0;
    cmd      <= '0;
    my_did   <= 8'($random(seed));
    host_did <= 8'($random(seed));
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // Config registers
    run_cmd(MEM_WR, local_addr(CFG_DEV, CFG_FREEZE_OFS), '0, '0, rd);
    exp_freeze = 1'b0;
    run_cmd(MEM_RD, local_addr(CFG_DEV, CFG_FREEZE_OFS), '0, '0, rd);
    wd = {$random(seed), $random(seed)};
    run_cmd(MEM_WR, local_addr(CFG_DEV, CFG_SCRATCH_OFS), wd, '0, rd);
    scratch = wd;
    run_cmd(MEM_RD, local_addr(CFG_DEV, CFG_SCRATCH_OFS), '0, scratch, rd);
    run_cmd(MEM_RD, local_addr(CFG_DEV, CFG_DID_OFS), '0, 64'(my_did), rd);
    run_cmd(MEM_RD, local_addr(CFG_DEV, CFG_HOST_DID_OFS), '0, 64'(host_did), rd);

    repeat (8) random_txn(0);
    repeat (4) random_txn(1);
    repeat (4) random_txn(2);

    // Interruptor
    run_cmd(MEM_WR, local_addr(CLINT_DEV, CLINT_MSIP_OFS), 64'd1, '0, rd);
    exp_msip = 1'b1;
    run_cmd(MEM_RD, local_addr(CLINT_DEV, CLINT_MSIP_OFS), '0, 64'd1, rd);
    run_cmd(MEM_WR, local_addr(CLINT_DEV, CLINT_MSIP_OFS), 64'd0, '0, rd);
    exp_msip = 1'b0;
    at_least = 1'b1;
    repeat (2) begin
      run_cmd(MEM_RD, local_addr(CLINT_DEV, CLINT_MTIME_OFS), '0, last_mtime, rd);
      last_mtime = rd;
    end
    at_least = 1'b0;
    run_cmd(MEM_WR, local_addr(CLINT_DEV, CLINT_MTIMECMP_OFS), last_mtime + 64'd8, '0, rd);
    cmp_set = 1'b1;
    t = 0;
    while (!timer_irq && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (!timer_irq) abort_run("timer interrupt did not rise");
    repeat (8) @(posedge clk);

    // Random mix under back-pressure
    bp_en <= 1'b1;
    repeat (24) random_txn($unsigned($random(seed)) % 5);
    bp_en <= 1'b0;
    repeat (4) @(posedge clk);

    a_count: assert (n_cmd == n_resp)
      else report_value("response count", 128'(n_resp), 128'(n_cmd));
    $display("Commands %0d, responses %0d, errors %0d", n_cmd, n_resp, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
